// File: dual_fetch.f
hw/ibus_pkg.sv
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/fetch_align.sv
hw/fetch_top.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: dual_fetch

sources:
  # design, packages first
  - files:
      - hw/ibus_pkg.sv
      - hw/fetch_pkg.sv
      - hw/pc_gen.sv
      - hw/fetch_align.sv
      - hw/fetch_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/fetch_assert.sv
      - tb/fetch_tb.sv

// File: tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import ibus_pkg::*;
    import fetch_pkg::*;

    // run length and watchdog
    localparam int stim_cycles    = 3000;
    localparam int timeout_cycles = 2 * stim_cycles;
    localparam int drain_packets  = 4;
    // memory contents are the address scrambled with this key
    localparam word_t data_key    = 32'h5A5A_5A5A;

    logic          clk;
    logic          reset;
    ibus_req_t     ireq;
    ibus_resp_t    iresp;
    redirect_t     redirect;
    logic          decode_stall;
    fetch_packet_t packet;

    integer seed;
    int     cycle_count = 0;
    // reference model state
    word_t  expected_pc;
    logic   exc_held;
    logic   flush_seen;
    // exception packets that made it to decode
    int     misaligned_seen;

    fetch_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .ireq         (ireq),
        .iresp        (iresp),
        .redirect     (redirect),
        .decode_stall (decode_stall),
        .packet       (packet)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now("value mismatch");
        end
    endtask

    task automatic check_covered(input string what, input int count);
        if (count == 0) begin
            fail_now({"never exercised: ", what});
        end
    endtask

    // 0..99
    function automatic int roll_percent();
        return ($random(seed) & 32'h7fff_ffff) % 100;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        return addr ^ data_key;
    endfunction

    function automatic redirect_t make_redirect(input redirect_kind_e kind, input word_t target);
        redirect_t rd;
        rd.valid  = 1'b1;
        rd.kind   = kind;
        rd.target = target;
        return rd;
    endfunction

    // one cycle of stimulus at the rising edge
    task automatic drive_cycle(input int cyc);
        logic      stall_v;
        redirect_t rd;
        int        roll;
        word_t     target;
        dword_t    data_v;
        stall_v = roll_percent() < 30;
        rd      = '0;
        roll    = roll_percent();
        if (roll < 3) begin
            target = reset_pc + ($random(seed) & 32'h0000_fffc);
            roll   = roll_percent();
            if (roll < 70) begin
                // occasional bad target
                if (roll_percent() < 10) begin
                    target = target + 1 + roll_percent() % 3;
                end
                rd = make_redirect(branch, target);
            end else if (roll < 85) begin
                rd = make_redirect(exception, target);
            end else begin
                rd = make_redirect(eret, target);
            end
        end
        // fixed corner cases on top of the random traffic
        case (cyc)
            1000: begin
                stall_v = 1'b1;
                rd      = make_redirect(exception, 32'h0);
            end
            1001: begin
                // must lose to the held exception
                stall_v = 1'b1;
                rd      = make_redirect(branch, reset_pc + 32'h100);
            end
            1002: begin
                stall_v = 1'b1;
                rd      = '0;
            end
            1500: begin
                stall_v = 1'b0;
                rd      = make_redirect(branch, reset_pc + 32'h202);
            end
            2000: begin
                stall_v = 1'b1;
                rd      = make_redirect(branch, reset_pc + 32'h400);
            end
            2001: begin
                stall_v = 1'b1;
                rd      = '0;
            end
            2500: begin
                stall_v = 1'b0;
                rd      = make_redirect(eret, reset_pc + 32'h600);
            end
            default: ;
        endcase
        // drain with decode quiet and one branch back to boot code
        if (cyc >= stim_cycles) begin
            stall_v = 1'b0;
            rd      = '0;
            if (cyc == stim_cycles) begin
                rd = make_redirect(branch, reset_pc);
            end
        end
        // memory answers one cycle after acceptance and sends junk otherwise
        if (ireq.valid && iresp.addr_ok) begin
            data_v = {mem_word(ireq.addr + 32'd4), mem_word(ireq.addr)};
        end else begin
            data_v = {$random(seed), $random(seed)};
        end
        decode_stall  <= stall_v;
        redirect      <= rd;
        iresp.addr_ok <= roll_percent() < 75;
        iresp.data    <= data_v;
    endtask

    task automatic check_packet();
        word_t pc1;
        pc1 = expected_pc;
        check_value("packet.slot1.pc", packet.slot1.pc, pc1);
        if (pc1[1:0] != 2'b00) begin
            check_value("packet.slot1.exc", packet.slot1.exc, 1);
            check_value("packet.slot1.instr", packet.slot1.instr, 0);
            check_value("packet.slot0.valid", packet.slot0.valid, 0);
            misaligned_seen++;
        end else begin
            check_value("packet.slot1.exc", packet.slot1.exc, 0);
            check_value("packet.slot1.instr", packet.slot1.instr, mem_word(pc1));
            check_value("packet.slot0.valid", packet.slot0.valid, 1);
            check_value("packet.slot0.pc", packet.slot0.pc, pc1 + 32'd4);
            check_value("packet.slot0.instr", packet.slot0.instr, mem_word(pc1 + 32'd4));
            check_value("packet.slot0.exc", packet.slot0.exc, 0);
        end
    endtask

    // reference model sees the values of the cycle that just ended
    always @(posedge clk) begin
        if (reset) begin
            expected_pc = reset_pc;
            exc_held    = 1'b0;
            flush_seen  = 1'b0;
        end else begin
            // leftovers are gone one cycle after a redirect
            if (flush_seen) begin
                check_value("packet.slot1.valid", packet.slot1.valid, 0);
            end
            if (ireq.valid) begin
                check_value("ireq.addr[1:0]", ireq.addr[1:0], 0);
            end
            if (!packet.slot1.valid) begin
                check_value("packet.slot0.valid", packet.slot0.valid, 0);
            end
            // consumed packet first since it predates any redirect of this cycle
            if (packet.slot1.valid && !decode_stall) begin
                check_packet();
                expected_pc = expected_pc + fetch_bytes;
            end
            // a branch behind a held exception or eret is dropped
            if (redirect.valid && !(redirect.kind == branch && exc_held)) begin
                expected_pc = (redirect.kind == exception) ? exc_entrance : redirect.target;
                if (decode_stall) begin
                    exc_held = redirect.kind != branch;
                end
            end
            // held redirect goes out on the first cycle without decode stall
            if (!decode_stall) begin
                exc_held = 1'b0;
            end
            flush_seen = redirect.valid;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            fail_now("timeout: drain never finished");
        end
    end

    initial begin
        int cyc;
        int drained;
        seed            = 91437;
        clk             = 1'b0;
        reset           = 1'b1;
        decode_stall    = 1'b0;
        redirect        = '0;
        iresp           = '0;
        misaligned_seen = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        drive_cycle(0);
        for (cyc = 1; cyc < stim_cycles; cyc++) begin
            @(posedge clk);
            drive_cycle(cyc);
        end
        // wait for a few packets after the final branch
        drained = 0;
        cyc     = stim_cycles;
        while (drained < drain_packets) begin
            @(posedge clk);
            if (packet.slot1.valid && !decode_stall) begin
                drained++;
            end
            drive_cycle(cyc);
            cyc++;
        end
        // let the last edge's checks finish
        @(negedge clk);
        check_covered("misaligned fetch", misaligned_seen);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tb/fetch_assert.sv
`timescale 1ns/1ps

module fetch_assert (
    input logic                     clk,
    input logic                     reset,
    input ibus_pkg::ibus_req_t      ireq,
    input fetch_pkg::redirect_t     redirect,
    input logic                     decode_stall,
    input fetch_pkg::fetch_packet_t packet
);
    import fetch_pkg::*;

    // bad pc never reaches the bus
    request_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ireq.valid |-> ireq.addr[1:0] == 2'b00
    ) else $error("request raised on misaligned address %h", ireq.addr);

    // back-pressure freezes the packet unless a redirect kills it
    packet_held: assert property (
        @(posedge clk) disable iff (reset)
        (decode_stall && packet.slot1.valid && !redirect.valid) |=> $stable(packet)
    ) else $error("packet changed under decode stall");

    // flush empties the output register
    flush_clears: assert property (
        @(posedge clk) disable iff (reset)
        redirect.valid |=> !packet.slot1.valid && !packet.slot0.valid
    ) else $error("packet still valid after redirect");

endmodule

bind fetch_top fetch_assert fetch_assert0 (.*);

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     reset,
    output ibus_pkg::ibus_req_t      ireq,
    input  ibus_pkg::ibus_resp_t     iresp,
    input  fetch_pkg::redirect_t     redirect,
    input  logic                     decode_stall,
    output fetch_pkg::fetch_packet_t packet
);
    import fetch_pkg::*;

    // pc stage to stage 1
    fetch1_t f1_next;
    logic    hold_f2;
    logic    flush;

    // pc, redirects and hazards
    pc_gen pc_gen0 (
        .clk           (clk),
        .reset         (reset),
        .redirect      (redirect),
        .decode_stall  (decode_stall),
        .iresp_addr_ok (iresp.addr_ok),
        .ireq          (ireq),
        .f1_next       (f1_next),
        .hold_f2       (hold_f2),
        .flush         (flush)
    );

    // bus word to two-slot packet
    fetch_align fetch_align0 (
        .clk          (clk),
        .reset        (reset),
        .f1_next      (f1_next),
        .hold_f2      (hold_f2),
        .flush        (flush),
        .decode_stall (decode_stall),
        .iresp_data   (iresp.data),
        .packet       (packet)
    );

endmodule

// File: hw/fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::fetch1_t       f1_next,
    input  logic                     hold_f2,
    input  logic                     flush,
    input  logic                     decode_stall,
    input  ibus_pkg::dword_t         iresp_data,
    output fetch_pkg::fetch_packet_t packet
);
    import ibus_pkg::*;
    import fetch_pkg::*;

    fetch1_t       f1;
    dword_t        word_hold;
    logic          word_held;
    dword_t        word;
    fetch_packet_t packet_next;

    // stage 1 entry
    // flush beats the hold
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            f1.valid <= 1'b0;
        end else if (!hold_f2) begin
            f1 <= f1_next;
        end
    end

    // bus data shows up only once, in the cycle after acceptance
    // grab it on the first held cycle
    always_ff @(posedge clk) begin
        if (hold_f2 && f1.valid && !word_held) begin
            word_hold <= iresp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush || !hold_f2) begin
            word_held <= 1'b0;
        end else if (f1.valid) begin
            word_held <= 1'b1;
        end
    end

    // live bus word unless one was parked
    assign word = word_held ? word_hold : iresp_data;

    // split into two slots
    always_comb begin
        packet_next.slot1.valid = f1.valid;
        packet_next.slot1.pc    = f1.pc;
        packet_next.slot1.instr = word[31:0];
        packet_next.slot1.exc   = f1.misaligned;

        packet_next.slot0.valid = f1.valid;
        packet_next.slot0.pc    = f1.pc + instr_bytes;
        packet_next.slot0.instr = word[63:32];
        packet_next.slot0.exc   = 1'b0;

        // a bad pc gives an exception in slot 1 and nothing in slot 0
        if (f1.misaligned) begin
            packet_next.slot1.instr = '0;
            packet_next.slot0.valid = 1'b0;
        end
    end

    // register toward decode
    // held as is under back-pressure
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            packet.slot1.valid <= 1'b0;
            packet.slot0.valid <= 1'b0;
        end else if (!decode_stall) begin
            packet <= packet_next;
        end
    end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 decode_stall,
    input  logic                 iresp_addr_ok,
    output ibus_pkg::ibus_req_t  ireq,
    output fetch_pkg::fetch1_t   f1_next,
    output logic                 hold_f2,
    output logic                 flush
);
    import ibus_pkg::*;
    import fetch_pkg::*;

    word_t     pc;
    logic      misaligned;
    logic      exc_sent;
    logic      stall;
    redirect_t live;
    redirect_t saved;
    redirect_t pending;

    // exception always goes to the fixed entrance
    always_comb begin
        live = redirect;
        if (redirect.kind == exception) begin
            live.target = exc_entrance;
        end
    end

    // newest redirect wins
    // except a branch behind a held exception or eret
    always_comb begin
        pending = saved;
        if (live.valid && !(saved.valid && saved.kind != branch && live.kind == branch)) begin
            pending = live;
        end
    end

    assign misaligned = pc[1:0] != 2'b00;

    // no request for a bad pc, under decode back-pressure,
    // or while the pc is about to be replaced
    assign ireq.valid = !misaligned && !decode_stall && !pending.valid;
    assign ireq.addr  = pc;

    // waiting on decode or on the bus
    assign stall = decode_stall || (ireq.valid && !iresp_addr_ok);

    // first stage only waits on decode
    // a bus wait just leaves a bubble in stage 1
    assign hold_f2 = decode_stall;

    // kill whatever is already in flight
    assign flush = redirect.valid;

    // accepted fetch, or a single exception entry for a bad pc
    assign f1_next.valid = (ireq.valid && iresp_addr_ok)
                         || (misaligned && !exc_sent && !decode_stall && !pending.valid);
    assign f1_next.pc         = pc;
    assign f1_next.misaligned = misaligned;

    // redirect held across a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            saved.valid <= 1'b0;
        end else if (stall) begin
            saved <= pending;
        end else begin
            saved.valid <= 1'b0;
        end
    end

    // pc register
    // a bad pc parks here until some redirect shows up
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall) begin
            if (pending.valid) begin
                pc <= pending.target;
            end else if (!misaligned) begin
                pc <= pc + fetch_bytes;
            end
        end
    end

    // one exception packet per bad pc
    always_ff @(posedge clk) begin
        if (reset) begin
            exc_sent <= 1'b0;
        end else if (!stall && pending.valid) begin
            exc_sent <= 1'b0;
        end else if (f1_next.valid && misaligned) begin
            exc_sent <= 1'b1;
        end
    end

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // boot vector
    localparam ibus_pkg::word_t reset_pc = 32'hBFC0_0000;
    // common exception entrance
    localparam ibus_pkg::word_t exc_entrance = 32'hBFC0_0380;
    // pc step per two-slot packet
    localparam ibus_pkg::word_t fetch_bytes = 32'd8;
    // slot 0 sits one instruction above slot 1
    localparam ibus_pkg::word_t instr_bytes = 32'd4;

    typedef enum logic [1:0] {
        branch,
        exception,
        eret
    } redirect_kind_e;

    // target unused for exception
    typedef struct packed {
        logic            valid;
        redirect_kind_e  kind;
        ibus_pkg::word_t target;
    } redirect_t;

    // entry waiting for its bus word
    typedef struct packed {
        logic            valid;
        ibus_pkg::word_t pc;
        logic            misaligned;
    } fetch1_t;

    typedef struct packed {
        logic            valid;
        ibus_pkg::word_t pc;
        ibus_pkg::word_t instr;
        logic            exc;
    } fetch_slot_t;

    // slot 1 at pc, slot 0 at pc+4
    typedef struct packed {
        fetch_slot_t slot1;
        fetch_slot_t slot0;
    } fetch_packet_t;

endpackage

// File: hw/ibus_pkg.sv
package ibus_pkg;

    // instruction bus widths
    localparam int addr_w = 32;
    localparam int data_w = 64;

    // one address or one instruction
    typedef logic [addr_w-1:0] word_t;

    // one bus beat, two instructions
    typedef logic [data_w-1:0] dword_t;

    // fetch request toward memory
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // memory answer
    // data belongs to the request accepted one cycle earlier
    typedef struct packed {
        logic   addr_ok;
        dword_t data;
    } ibus_resp_t;

endpackage
